// File: design/mips_pkg.sv
package mips_pkg;

	localparam int XLEN = 32; // Data word width
	localparam int PC_W = 7; // PC counts words, not bytes
	localparam int IMEM_DEPTH = 128; // One entry per PC value
	localparam int DMEM_DEPTH = 32;
	localparam int DMEM_AW = $clog2(DMEM_DEPTH); // Low address bits used by data memory
	localparam int REG_AW = 5; // 32 architectural registers

	// Primary opcodes, standard MIPS encodings
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] OP_BEQ = 6'h04;

	// R-type function field
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// Internal ALU operation, decode to execute
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;

	// Operand source select in execute
	localparam logic [1:0] FWD_NONE = 2'd0; // Value read in decode
	localparam logic [1:0] FWD_MEM = 2'd1; // EX/MEM ALU result
	localparam logic [1:0] FWD_WB = 2'd2; // Writeback value

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r; // Register format view
		i_fields_t i; // Immediate format view
	} instr_u;

endpackage

// File: design/hazard_if.sv
`timescale 1ns/1ns

interface hazard_if;

	logic [mips_pkg::REG_AW-1:0] id_rs; // Zero when decode reads no rs
	logic [mips_pkg::REG_AW-1:0] id_rt; // Zero when decode reads no rt
	logic id_uses_rt;
	logic id_is_branch;

	logic [mips_pkg::REG_AW-1:0] ex_rs; // ID/EX source fields
	logic [mips_pkg::REG_AW-1:0] ex_rt;
	logic [mips_pkg::REG_AW-1:0] ex_dst;
	logic ex_reg_write;
	logic ex_mem_to_reg; // Load in execute

	logic [mips_pkg::REG_AW-1:0] mem_dst; // EX/MEM writer
	logic mem_reg_write;
	logic [mips_pkg::REG_AW-1:0] wb_dst; // MEM/WB writer
	logic wb_reg_write;

	logic stall;
	logic [1:0] fwd_a; // Operand A source in execute
	logic [1:0] fwd_b; // Operand B source in execute

	modport decode (output id_rs, id_rt, id_uses_rt, id_is_branch, input stall);
	modport execute (output ex_rs, ex_rt, ex_dst, ex_reg_write, ex_mem_to_reg,
		input fwd_a, fwd_b);
	modport memory (output mem_dst, mem_reg_write, wb_dst, wb_reg_write);
	modport control (input id_rs, id_rt, id_uses_rt, id_is_branch,
		input ex_rs, ex_rt, ex_dst, ex_reg_write, ex_mem_to_reg,
		input mem_dst, mem_reg_write, wb_dst, wb_reg_write,
		output stall, fwd_a, fwd_b);

endinterface

// File: design/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic stall,
	input logic taken,
	input logic [mips_pkg::PC_W-1:0] branch_pc,
	input logic imem_write,
	input logic [mips_pkg::PC_W-1:0] imem_addr,
	input logic [mips_pkg::XLEN-1:0] imem_data,
	output logic [mips_pkg::PC_W-1:0] pc,
	output mips_pkg::instr_u if_instr,
	output logic [mips_pkg::PC_W-1:0] if_next_pc
);

	logic [mips_pkg::XLEN-1:0] imem [mips_pkg::IMEM_DEPTH]; // Word-addressed program store
	logic [mips_pkg::PC_W-1:0] pc_plus1;

	assign pc_plus1 = pc + (mips_pkg::PC_W)'(1); // Sequential successor

	// Program load port, testbench only writes it with enable low
	always_ff @(posedge clk) begin
		if (imem_write)
			imem[imem_addr] <= imem_data;
	end

	// PC and IF/ID register
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			if_instr <= '0; // All-zero word decodes as nop
		end else if (enable) begin
			if (taken) begin
				pc <= branch_pc; // Redirect to branch target
				if_instr <= '0; // Squash the wrong-path fetch
			end else if (!stall) begin
				pc <= pc_plus1;
				if_instr <= imem[pc];
				if_next_pc <= pc_plus1; // Base for branch offset
			end
		end
	end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input logic clk,
	input logic reset,
	input logic enable,
	input mips_pkg::instr_u if_instr,
	input logic [mips_pkg::PC_W-1:0] if_next_pc,
	input logic wb_write,
	input logic [mips_pkg::REG_AW-1:0] wb_reg,
	input logic [mips_pkg::XLEN-1:0] wb_data,
	hazard_if.decode hz,
	output logic taken,
	output logic [mips_pkg::PC_W-1:0] branch_pc,
	output logic [mips_pkg::XLEN-1:0] ex_data1,
	output logic [mips_pkg::XLEN-1:0] ex_data2,
	output logic [mips_pkg::XLEN-1:0] ex_imm,
	output logic [2:0] ex_alu_op,
	output logic ex_alu_src,
	output logic ex_mem_write,
	output logic [mips_pkg::REG_AW-1:0] ex_rs,
	output logic [mips_pkg::REG_AW-1:0] ex_rt,
	output logic [mips_pkg::REG_AW-1:0] ex_dst,
	output logic ex_reg_write,
	output logic ex_mem_to_reg
);

	logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_AW]; // Register file
	logic [mips_pkg::XLEN-1:0] rd1;
	logic [mips_pkg::XLEN-1:0] rd2;
	logic [mips_pkg::XLEN-1:0] imm_ext;
	logic [mips_pkg::REG_AW-1:0] rs;
	logic [mips_pkg::REG_AW-1:0] rt;
	logic [mips_pkg::REG_AW-1:0] dst;
	logic [2:0] alu_op;
	logic uses_rs, uses_rt, is_branch; // Operand and branch flags
	logic reg_write, mem_write, mem_to_reg, alu_src;

	assign rs = if_instr.r.rs;
	assign rt = if_instr.r.rt;
	assign imm_ext = {{(mips_pkg::XLEN-16){if_instr.i.imm[15]}}, if_instr.i.imm};

	// Same-cycle writeback bypasses the array, r0 reads as zero
	assign rd1 = (rs == '0) ? '0 : (wb_write && wb_reg == rs) ? wb_data : regs[rs];
	assign rd2 = (rt == '0) ? '0 : (wb_write && wb_reg == rt) ? wb_data : regs[rt];

	always_ff @(posedge clk) begin
		if (enable && wb_write)
			regs[wb_reg] <= wb_data; // wb_reg never zero
	end

	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_branch = 1'b0;
		reg_write = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_src = 1'b0;
		alu_op = mips_pkg::ALU_ADD;
		dst = if_instr.i.rt; // I-format target by default
		case (if_instr.r.op)
			mips_pkg::OP_RTYPE: begin
				dst = if_instr.r.rd;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				reg_write = 1'b1;
				case (if_instr.r.funct)
					mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					default: begin // Unknown funct retires as nop
						uses_rs = 1'b0;
						uses_rt = 1'b0;
						reg_write = 1'b0;
					end
				endcase
			end
			mips_pkg::OP_ADDI: begin
				uses_rs = 1'b1;
				reg_write = 1'b1;
				alu_src = 1'b1;
			end
			mips_pkg::OP_LW: begin
				uses_rs = 1'b1;
				reg_write = 1'b1;
				mem_to_reg = 1'b1;
				alu_src = 1'b1; // Base plus offset
			end
			mips_pkg::OP_SW: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1; // Store data
				mem_write = 1'b1;
				alu_src = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				is_branch = 1'b1;
			end
			default: ; // Everything else is a nop
		endcase
		if (dst == '0)
			reg_write = 1'b0; // r0 is never written
	end

	assign hz.id_rs = uses_rs ? rs : '0;
	assign hz.id_rt = uses_rt ? rt : '0;
	assign hz.id_uses_rt = uses_rt;
	assign hz.id_is_branch = is_branch;

	// Compare resolves in decode, held off while operands are in flight
	assign taken = is_branch && (rd1 == rd2) && !hz.stall;
	assign branch_pc = if_next_pc + imm_ext[mips_pkg::PC_W-1:0];

	// ID/EX register
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_reg_write <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_mem_to_reg <= 1'b0;
		end else if (enable) begin
			ex_reg_write <= reg_write && !hz.stall; // Bubble on stall
			ex_mem_write <= mem_write && !hz.stall;
			ex_mem_to_reg <= mem_to_reg && !hz.stall;
			ex_data1 <= rd1;
			ex_data2 <= rd2;
			ex_imm <= imm_ext;
			ex_alu_op <= alu_op;
			ex_alu_src <= alu_src;
			ex_rs <= hz.id_rs;
			ex_rt <= hz.id_rt;
			ex_dst <= dst;
		end
	end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic [mips_pkg::XLEN-1:0] ex_data1,
	input logic [mips_pkg::XLEN-1:0] ex_data2,
	input logic [mips_pkg::XLEN-1:0] ex_imm,
	input logic [2:0] ex_alu_op,
	input logic ex_alu_src,
	input logic ex_mem_write,
	input logic [mips_pkg::REG_AW-1:0] ex_rs,
	input logic [mips_pkg::REG_AW-1:0] ex_rt,
	input logic [mips_pkg::REG_AW-1:0] ex_dst,
	input logic ex_reg_write,
	input logic ex_mem_to_reg,
	input logic [mips_pkg::XLEN-1:0] mem_alu_result,
	input logic [mips_pkg::XLEN-1:0] wb_data,
	hazard_if.execute hz,
	output logic [mips_pkg::XLEN-1:0] mem_alu_result_q,
	output logic [mips_pkg::XLEN-1:0] mem_store_data,
	output logic mem_write,
	output logic [mips_pkg::REG_AW-1:0] mem_dst,
	output logic mem_reg_write,
	output logic mem_to_reg
);

	logic [mips_pkg::XLEN-1:0] op_a; // Forwarded rs value
	logic [mips_pkg::XLEN-1:0] op_b; // Forwarded rt value
	logic [mips_pkg::XLEN-1:0] alu_b;
	logic [mips_pkg::XLEN-1:0] alu_y;

	// Hazard unit sees the ID/EX fields directly
	assign hz.ex_rs = ex_rs;
	assign hz.ex_rt = ex_rt;
	assign hz.ex_dst = ex_dst;
	assign hz.ex_reg_write = ex_reg_write;
	assign hz.ex_mem_to_reg = ex_mem_to_reg;

	always_comb begin
		case (hz.fwd_a)
			mips_pkg::FWD_MEM: op_a = mem_alu_result;
			mips_pkg::FWD_WB: op_a = wb_data;
			default: op_a = ex_data1;
		endcase
		case (hz.fwd_b)
			mips_pkg::FWD_MEM: op_b = mem_alu_result;
			mips_pkg::FWD_WB: op_b = wb_data;
			default: op_b = ex_data2;
		endcase
	end

	assign alu_b = ex_alu_src ? ex_imm : op_b; // Immediate for addi, lw, sw

	always_comb begin
		case (ex_alu_op)
			mips_pkg::ALU_SUB: alu_y = op_a - alu_b;
			mips_pkg::ALU_AND: alu_y = op_a & alu_b;
			mips_pkg::ALU_OR: alu_y = op_a | alu_b;
			mips_pkg::ALU_SLT: alu_y = {{(mips_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_y = op_a + alu_b;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_to_reg <= 1'b0;
		end else if (enable) begin
			mem_write <= ex_mem_write;
			mem_reg_write <= ex_reg_write;
			mem_to_reg <= ex_mem_to_reg;
			mem_alu_result_q <= alu_y;
			mem_store_data <= op_b; // sw data after forwarding
			mem_dst <= ex_dst;
		end
	end

endmodule

// File: design/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic [mips_pkg::XLEN-1:0] mem_alu_result_q,
	input logic [mips_pkg::XLEN-1:0] mem_store_data,
	input logic mem_write,
	input logic [mips_pkg::REG_AW-1:0] mem_dst,
	input logic mem_reg_write,
	input logic mem_to_reg,
	hazard_if.memory hz,
	output logic wb_write,
	output logic [mips_pkg::REG_AW-1:0] wb_reg,
	output logic [mips_pkg::XLEN-1:0] wb_data
);

	logic [mips_pkg::XLEN-1:0] dmem [mips_pkg::DMEM_DEPTH]; // Word-indexed data store
	logic [mips_pkg::DMEM_AW-1:0] dmem_idx;
	logic [mips_pkg::XLEN-1:0] load_data; // Asynchronous read
	logic [mips_pkg::XLEN-1:0] wb_alu;
	logic [mips_pkg::XLEN-1:0] wb_load;
	logic wb_mem_to_reg;

	assign dmem_idx = mem_alu_result_q[mips_pkg::DMEM_AW-1:0]; // Address wraps at 32 words
	assign load_data = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (enable && mem_write)
			dmem[dmem_idx] <= mem_store_data;
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_write <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end else if (enable) begin
			wb_write <= mem_reg_write;
			wb_mem_to_reg <= mem_to_reg;
			wb_alu <= mem_alu_result_q;
			wb_load <= load_data;
			wb_reg <= mem_dst;
		end
	end

	assign wb_data = wb_mem_to_reg ? wb_load : wb_alu; // Writeback select

	assign hz.mem_dst = mem_dst;
	assign hz.mem_reg_write = mem_reg_write;
	assign hz.wb_dst = wb_reg;
	assign hz.wb_reg_write = wb_write;

endmodule

// File: design/hazard_control.sv
`timescale 1ns/1ns

module hazard_control (
	hazard_if.control hz
);

	logic load_use; // Load in EX feeds decode
	logic branch_dep; // beq operand still in flight
	logic ex_hit_rs, ex_hit_rt;
	logic mem_hit_rs, mem_hit_rt;

	// Writer matches against decode operands, r0 never matches
	assign ex_hit_rs = hz.ex_reg_write && hz.ex_dst != '0 && hz.ex_dst == hz.id_rs;
	assign ex_hit_rt = hz.ex_reg_write && hz.ex_dst != '0 && hz.id_uses_rt
		&& hz.ex_dst == hz.id_rt;
	assign mem_hit_rs = hz.mem_reg_write && hz.mem_dst != '0 && hz.mem_dst == hz.id_rs;
	assign mem_hit_rt = hz.mem_reg_write && hz.mem_dst != '0 && hz.id_uses_rt
		&& hz.mem_dst == hz.id_rt;

	// One bubble lets the load reach writeback, then WB forwarding covers it
	assign load_use = hz.ex_mem_to_reg && (ex_hit_rs || ex_hit_rt);

	// Branch compares in decode, so wait until the writer sits in writeback
	assign branch_dep = hz.id_is_branch && (ex_hit_rs || ex_hit_rt || mem_hit_rs || mem_hit_rt);

	assign hz.stall = load_use || branch_dep;

	// Youngest writer wins, MEM ahead of WB
	always_comb begin
		hz.fwd_a = mips_pkg::FWD_NONE;
		if (hz.mem_reg_write && hz.mem_dst != '0 && hz.mem_dst == hz.ex_rs)
			hz.fwd_a = mips_pkg::FWD_MEM;
		else if (hz.wb_reg_write && hz.wb_dst != '0 && hz.wb_dst == hz.ex_rs)
			hz.fwd_a = mips_pkg::FWD_WB;
	end

	always_comb begin
		hz.fwd_b = mips_pkg::FWD_NONE;
		if (hz.mem_reg_write && hz.mem_dst != '0 && hz.mem_dst == hz.ex_rt)
			hz.fwd_b = mips_pkg::FWD_MEM;
		else if (hz.wb_reg_write && hz.wb_dst != '0 && hz.wb_dst == hz.ex_rt)
			hz.fwd_b = mips_pkg::FWD_WB;
	end

endmodule

// File: design/mips_pipeline.sv
`timescale 1ns/1ns

module mips_pipeline (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic imem_write,
	input logic [mips_pkg::PC_W-1:0] imem_addr,
	input logic [mips_pkg::XLEN-1:0] imem_data,
	output logic [mips_pkg::PC_W-1:0] pc,
	output logic [mips_pkg::XLEN-1:0] instruction,
	output logic stall,
	output logic wb_write,
	output logic [mips_pkg::REG_AW-1:0] wb_reg,
	output logic [mips_pkg::XLEN-1:0] wb_data
);

	hazard_if hz (); // Hazard and forwarding bundle

	mips_pkg::instr_u if_instr; // IF/ID
	logic [mips_pkg::PC_W-1:0] if_next_pc;
	logic taken;
	logic [mips_pkg::PC_W-1:0] branch_pc;

	logic [mips_pkg::XLEN-1:0] ex_data1, ex_data2, ex_imm; // ID/EX
	logic [2:0] ex_alu_op;
	logic ex_alu_src, ex_mem_write, ex_reg_write, ex_mem_to_reg;
	logic [mips_pkg::REG_AW-1:0] ex_rs, ex_rt, ex_dst;

	logic [mips_pkg::XLEN-1:0] mem_alu_result_q, mem_store_data; // EX/MEM
	logic mem_write, mem_reg_write, mem_to_reg;
	logic [mips_pkg::REG_AW-1:0] mem_dst;

	assign instruction = if_instr;
	assign stall = hz.stall;

	fetch_stage u_fetch (
		.clk(clk), .reset(reset), .enable(enable),
		.stall(hz.stall), .taken(taken), .branch_pc(branch_pc),
		.imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
		.pc(pc), .if_instr(if_instr), .if_next_pc(if_next_pc)
	);

	decode_stage u_decode (
		.clk(clk), .reset(reset), .enable(enable),
		.if_instr(if_instr), .if_next_pc(if_next_pc),
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data), // Register file write port
		.hz(hz), .taken(taken), .branch_pc(branch_pc),
		.ex_data1(ex_data1), .ex_data2(ex_data2), .ex_imm(ex_imm),
		.ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_mem_write(ex_mem_write),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dst(ex_dst),
		.ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg)
	);

	execute_stage u_execute (
		.clk(clk), .reset(reset), .enable(enable),
		.ex_data1(ex_data1), .ex_data2(ex_data2), .ex_imm(ex_imm),
		.ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_mem_write(ex_mem_write),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dst(ex_dst),
		.ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg),
		.mem_alu_result(mem_alu_result_q), .wb_data(wb_data), // Forwarding sources
		.hz(hz),
		.mem_alu_result_q(mem_alu_result_q), .mem_store_data(mem_store_data),
		.mem_write(mem_write), .mem_dst(mem_dst),
		.mem_reg_write(mem_reg_write), .mem_to_reg(mem_to_reg)
	);

	memory_stage u_memory (
		.clk(clk), .reset(reset), .enable(enable),
		.mem_alu_result_q(mem_alu_result_q), .mem_store_data(mem_store_data),
		.mem_write(mem_write), .mem_dst(mem_dst),
		.mem_reg_write(mem_reg_write), .mem_to_reg(mem_to_reg),
		.hz(hz),
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	hazard_control u_hazard (
		.hz(hz)
	);

endmodule

// File: testbench/mips_pipeline_properties.sv
`timescale 1ns/1ns

module mips_pipeline_properties (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic [mips_pkg::PC_W-1:0] pc,
	input logic stall,
	input logic wb_write,
	input logic [mips_pkg::REG_AW-1:0] wb_reg
);

	int unsigned failures = 0; // Failed property count

	// Outputs come out of reset quiet, PC at word 0
	after_reset: assert property (@(posedge clk) reset |=> (!stall && !wb_write && pc == '0))
		else begin
			$error("stall, wb_write or pc not cleared in the cycle after reset");
			failures++;
		end

	// Stall or freeze holds the fetch address
	pc_hold: assert property (@(posedge clk) (!reset && (stall || !enable)) |=> $stable(pc))
		else begin
			$error("pc changed while stalled or with enable low");
			failures++;
		end

	// r0 writes are dropped in decode
	no_r0_write: assert property (@(posedge clk) disable iff (reset) wb_write |-> wb_reg != '0)
		else begin
			$error("writeback reported register 0");
			failures++;
		end

	// Worst case is a beq waiting on a writer in execute, two cycles
	stall_length: assert property (@(posedge clk) disable iff (reset)
		!(stall && enable && $past(stall && enable) && $past(stall && enable, 2)))
		else begin
			$error("stall lasted more than two enabled cycles");
			failures++;
		end

endmodule

bind mips_pipeline mips_pipeline_properties props (
	.clk(clk),
	.reset(reset),
	.enable(enable),
	.pc(pc),
	.stall(stall),
	.wb_write(wb_write),
	.wb_reg(wb_reg)
);

// File: testbench/tb_mips_pipeline.sv
`timescale 1ns/1ns

module tb_mips_pipeline;

	logic clk = 1'b0;
	logic reset;
	logic enable;
	logic imem_write;
	logic [mips_pkg::PC_W-1:0] imem_addr;
	logic [mips_pkg::XLEN-1:0] imem_data;
	logic [mips_pkg::PC_W-1:0] pc;
	logic [mips_pkg::XLEN-1:0] instruction;
	logic stall;
	logic wb_write;
	logic [mips_pkg::REG_AW-1:0] wb_reg;
	logic [mips_pkg::XLEN-1:0] wb_data;

	logic [31:0] prog [$]; // Program words, address 0 first
	logic [31:0] model_regs [32]; // Model state persists across tests, as the DUT's does
	logic [31:0] model_mem [32];
	logic [4:0] exp_reg [$]; // Expected writeback stream, oldest first
	logic [31:0] exp_data [$];
	logic [31:0] halt_word = {mips_pkg::OP_BEQ, 10'd0, 16'hffff}; // beq r0, r0, -1
	int timeout_cycles = 400;
	int errors = 0;
	int tests = 0;
	int passed = 0;
	int retired; // Writebacks seen in the current test
	int stall_cycles; // Enabled cycles with stall high
	integer seed = 24303;

	mips_pipeline dut (
		.clk(clk), .reset(reset), .enable(enable),
		.imem_write(imem_write), .imem_addr(imem_addr), .imem_data(imem_data),
		.pc(pc), .instruction(instruction), .stall(stall),
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic rtype(input logic [5:0] funct, input int rd, input int rs, input int rt);
		prog.push_back({mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct});
	endtask

	task automatic itype(input logic [5:0] op, input int rt, input int rs, input int imm);
		prog.push_back({op, 5'(rs), 5'(rt), 16'(imm)});
	endtask

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// In-order ISA reference, one instruction per step until the halt word
	task automatic run_model();
		int mpc;
		int steps;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] y;
		logic [4:0] dst;
		logic [4:0] addr;
		logic wr;
		exp_reg.delete();
		exp_data.delete();
		mpc = 0;
		steps = 0;
		while (mpc < prog.size() && prog[mpc] != halt_word && steps < 500) begin
			w = prog[mpc];
			a = model_regs[w[25:21]]; // r0 never written, stays zero
			b = model_regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = 5'(a + imm); // 32-word data memory wraps
			dst = w[20:16];
			y = '0;
			wr = 1'b0;
			mpc = mpc + 1;
			steps++;
			case (w[31:26])
				mips_pkg::OP_RTYPE: begin
					dst = w[15:11];
					wr = 1'b1;
					case (w[5:0])
						mips_pkg::FN_ADD: y = a + b;
						mips_pkg::FN_SUB: y = a - b;
						mips_pkg::FN_AND: y = a & b;
						mips_pkg::FN_OR: y = a | b;
						mips_pkg::FN_SLT: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0; // Unknown funct is a nop
					endcase
				end
				mips_pkg::OP_ADDI: begin
					y = a + imm;
					wr = 1'b1;
				end
				mips_pkg::OP_LW: begin
					y = model_mem[addr];
					wr = 1'b1;
				end
				mips_pkg::OP_SW: model_mem[addr] = b;
				mips_pkg::OP_BEQ: begin
					if (a == b)
						mpc = int'((mpc + imm) & 32'h7f); // Target relative to pc plus 1
				end
				default: ;
			endcase
			if (wr && dst != 5'd0) begin
				model_regs[dst] = y;
				exp_reg.push_back(dst);
				exp_data.push_back(y);
			end
		end
		if (steps >= 500) begin
			$display("Model did not reach the halt instruction");
			errors++;
		end
	endtask

	// Writes the program with enable low, then resets for 3 cycles and enables
	task automatic load_program();
		enable <= 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			imem_write <= 1'b1;
			imem_addr <= 7'(i);
			imem_data <= prog[i];
		end
		@(posedge clk);
		imem_write <= 1'b0;
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		enable <= 1'b1;
	endtask

	// Freeze for six cycles, nothing visible may move
	task automatic hold_pipeline();
		logic [mips_pkg::PC_W-1:0] held_pc;
		logic [31:0] held_instr;
		enable <= 1'b0;
		@(posedge clk);
		held_pc = pc; // State after the last enabled edge
		held_instr = instruction;
		repeat (6) begin
			@(posedge clk);
			assert (pc == held_pc && instruction == held_instr)
			else begin
				$display("Fail %0t: pipeline moved with enable low, pc %0d instruction %h",
					$time, pc, instruction);
				errors++;
			end
		end
		enable <= 1'b1;
	endtask

	// Done once every expected write retired and the halt sits in IF/ID
	task automatic wait_for_halt(input int freeze_at);
		int cycles;
		bit frozen;
		cycles = 0;
		frozen = 1'b0;
		while (!(exp_reg.size() == 0 && instruction == halt_word) && cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
			if (freeze_at > 0 && !frozen && retired >= freeze_at) begin
				frozen = 1'b1;
				hold_pipeline();
			end
		end
		if (!(exp_reg.size() == 0 && instruction == halt_word)) begin
			$display("Timeout: program did not finish within %0d cycles, %0d writes missing",
				timeout_cycles, exp_reg.size());
			errors++;
		end
	endtask

	task automatic run_test(input string name, input int freeze_at, input int stalls_expected);
		int errors_before;
		errors_before = errors;
		tests++;
		run_model();
		retired = 0;
		stall_cycles = 0;
		load_program();
		wait_for_halt(freeze_at);
		repeat (4) @(posedge clk); // Drain, catches stray writes behind the last one
		enable <= 1'b0;
		if (stalls_expected >= 0) begin
			assert (stall_cycles == stalls_expected)
			else begin
				$display("Fail %0t: stall high for %0d cycles, expected %0d",
					$time, stall_cycles, stalls_expected);
				errors++;
			end
		end
		if (errors == errors_before)
			passed++;
		$display("%-22s %s, %0d writebacks", name,
			(errors == errors_before) ? "passed" : "failed", retired);
	endtask

	// Writeback checker, sampled before the edge commits the register file
	always @(posedge clk) begin
		if (enable && stall)
			stall_cycles++;
		if (enable && wb_write) begin
			assert (exp_reg.size() > 0)
			else begin
				$display("Writeback to r%0d at %0t was not expected", wb_reg, $time);
				errors++;
			end
			if (exp_reg.size() > 0) begin
				assert (wb_reg == exp_reg[0] && wb_data == exp_data[0])
				else begin
					$display("Fail %0t: writeback r%0d = %h, expected r%0d = %h",
						$time, wb_reg, wb_data, exp_reg[0], exp_data[0]);
					errors++;
				end
				exp_reg.delete(0);
				exp_data.delete(0);
				retired++;
			end
		end
	end

	initial begin
		int kind;
		reset <= 1'b1;
		enable <= 1'b0;
		imem_write <= 1'b0;
		imem_addr <= '0;
		imem_data <= '0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
			model_mem[r] = '0;
		end

		// Each result feeds the next, MEM and WB forwarding
		prog.delete();
		itype(mips_pkg::OP_ADDI, 1, 0, 5);
		itype(mips_pkg::OP_ADDI, 2, 1, 3);
		rtype(mips_pkg::FN_ADD, 3, 2, 1);
		rtype(mips_pkg::FN_SUB, 4, 3, 2);
		rtype(mips_pkg::FN_AND, 5, 4, 3);
		rtype(mips_pkg::FN_OR, 6, 5, 2);
		rtype(mips_pkg::FN_SLT, 7, 4, 6);
		itype(mips_pkg::OP_ADDI, 1, 7, -2);
		rtype(mips_pkg::FN_SLT, 2, 1, 0); // Signed compare of -1
		prog.push_back(halt_word);
		run_test("dependent arithmetic", 0, -1);

		prog.delete();
		itype(mips_pkg::OP_ADDI, 1, 0, 77);
		itype(mips_pkg::OP_ADDI, 2, 0, 5);
		itype(mips_pkg::OP_SW, 1, 2, 3); // mem[8] = r1
		itype(mips_pkg::OP_LW, 3, 2, 3);
		rtype(mips_pkg::FN_ADD, 4, 3, 1); // Load-use, one bubble
		itype(mips_pkg::OP_SW, 4, 2, 4);
		itype(mips_pkg::OP_LW, 5, 2, 4);
		prog.push_back(halt_word);
		run_test("load-use", 0, 1);

		prog.delete();
		itype(mips_pkg::OP_ADDI, 1, 0, 4);
		itype(mips_pkg::OP_ADDI, 2, 0, 4);
		itype(mips_pkg::OP_BEQ, 2, 1, 2); // Taken, waits on r2
		itype(mips_pkg::OP_ADDI, 3, 0, 99); // Skipped
		itype(mips_pkg::OP_ADDI, 3, 0, 98); // Skipped
		itype(mips_pkg::OP_ADDI, 4, 0, 7);
		itype(mips_pkg::OP_BEQ, 1, 4, 1); // Not taken, waits on r4
		itype(mips_pkg::OP_ADDI, 5, 0, 1);
		itype(mips_pkg::OP_BEQ, 0, 0, 1);
		itype(mips_pkg::OP_ADDI, 6, 0, 55); // Skipped
		itype(mips_pkg::OP_ADDI, 6, 1, 1);
		prog.push_back(halt_word);
		run_test("branches", 0, -1);

		prog.delete();
		itype(mips_pkg::OP_ADDI, 1, 0, 10);
		itype(mips_pkg::OP_ADDI, 2, 0, 20);
		rtype(mips_pkg::FN_ADD, 3, 1, 2);
		itype(mips_pkg::OP_SW, 3, 0, 0);
		itype(mips_pkg::OP_LW, 4, 0, 0);
		rtype(mips_pkg::FN_SUB, 5, 4, 1);
		rtype(mips_pkg::FN_OR, 6, 5, 3);
		rtype(mips_pkg::FN_ADD, 7, 6, 6);
		prog.push_back(halt_word);
		run_test("freeze", 3, -1);

		// r1 to r7 already hold known values from the earlier programs
		prog.delete();
		for (int n = 0; n < 20; n++) begin
			kind = random_below(6);
			case (kind)
				0: rtype(mips_pkg::FN_ADD, random_below(8), random_below(8), random_below(8));
				1: rtype(mips_pkg::FN_SUB, random_below(8), random_below(8), random_below(8));
				2: rtype(mips_pkg::FN_AND, random_below(8), random_below(8), random_below(8));
				3: rtype(mips_pkg::FN_OR, random_below(8), random_below(8), random_below(8));
				4: rtype(mips_pkg::FN_SLT, random_below(8), random_below(8), random_below(8));
				default: itype(mips_pkg::OP_ADDI, random_below(8), random_below(8),
					random_below(4096) - 2048);
			endcase
		end
		prog.push_back(halt_word);
		run_test("random arithmetic", 0, -1);

		$display("tests %0d, passed %0d, failed %0d, check errors %0d, property failures %0d",
			tests, passed, tests - passed, errors, dut.props.failures);
		if (errors == 0 && dut.props.failures == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: build.f
design/mips_pkg.sv
design/hazard_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_control.sv
design/mips_pipeline.sv
testbench/mips_pipeline_properties.sv
testbench/tb_mips_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_pipeline -f build.f \
	&& ./obj_dir/Vtb_mips_pipeline > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
